//--- periph_golden.txt
// columns: op addr be wdata expect budget, all hex
// op 0 write, 1 read, 2 poll read, 3 wait for {irq, id}, 4 read right behind the line before
0 02000008 f 11111111 0 0
0 02000108 f 22222222 0 0
0 02000208 f 33333333 0 0
1 02000008 f 0 11111111 0
1 02000108 f 0 22222222 0
1 02000208 f 0 33333333 0
0 02000004 f deadbeef 0 0   // value is read only
1 02000004 f 0 0 0
0 02000108 5 aabbccdd 0 0   // bytes 0 and 2 only
1 02000108 f 0 22bb22dd 0
1 04000000 f 0 0 0          // unmapped
0 02000008 f 5 0 0
0 02000000 f 1 0 0
2 02000000 f 0 5 14         // 2*(5+1)+8
0 02000000 f 0 0 0
0 02000000 f 4 0 0          // clear pending
1 02000000 f 0 0 0
0 02000108 f 3 0 0
0 02000208 f 4 0 0
0 03000000 f 6 0 0
0 02000100 f 3 0 0
0 02000200 f 3 0 0
2 02000200 f 0 7 12         // 2*(4+1)+8
3 0 0 0 101 a
0 02000100 f 0 0 0
0 02000100 f 4 0 0
3 0 0 0 102 a
1 03000004 f 0 4 0
0 03000000 f 0 0 0
3 0 0 0 0 a
1 03000000 f 0 0 0
1 02000008 f 0 5 0
4 02000108 f 0 3 0
4 02000208 f 0 4 0
4 02000300 f 0 0 0
4 03000004 f 0 4 0
4 02000000 f 0 0 0

//--- filelist.f
+incdir+.
periph_pkg.sv
obi_slave_decoder.sv
timer_unit.sv
rvic_ctrl.sv
periph_subsys_top.sv
tb_periph_subsys.sv

//--- Bender.yml
package:
  name: periph_subsys

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - obi_slave_decoder.sv
      - timer_unit.sv
      - rvic_ctrl.sv
      - periph_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_periph_subsys.sv

//--- tb_periph_subsys.sv
module tb_periph_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIELDS   = 6;
    localparam int MAX_OPS  = 64;
    localparam int F_OP     = 0;
    localparam int F_ADDR   = 1;
    localparam int F_BE     = 2;
    localparam int F_DATA   = 3;
    localparam int F_EXP    = 4;
    localparam int F_BUDGET = 5;
    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_POLL  = 2;
    localparam int OP_IRQ   = 3;
    localparam int OP_CHAIN = 4;    // read issued right behind the line before

    logic                clk_i;
    logic                rst_n_i;
    logic                req_i;
    logic                we_i;
    periph_pkg::be_t     be_i;
    periph_pkg::addr_t   addr_i;
    periph_pkg::data_t   wdata_i;
    logic                gnt_o;
    logic                rvalid_o;
    periph_pkg::data_t   rdata_o;
    logic                irq_o;
    periph_pkg::irq_id_t irq_id_o;

    logic [31:0] golden [FIELDS*MAX_OPS];
    int          idle   [MAX_OPS];
    int          n_ops;
    int          err_cnt      = 0;
    int          cycle_cnt    = 0;
    int          limit_cycles = 0;
    logic [31:0] last_rdata;

    periph_subsys_top i_periph_subsys_top (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] field_of(input int line, input int f);
        return golden[FIELDS*line + f];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            err_cnt++;
        end
    endtask

    // issues count requests back to back and takes the responses in order
    task automatic run_accesses(input int first, input int count, input bit compare);
        int issued;
        int got;
        int line;
        issued = 0;
        got    = 0;
        while (got < count) begin
            @(posedge clk_i);
            if (issued < count) begin
                line = first + issued;
                req_i   <= 1'b1;
                we_i    <= (field_of(line, F_OP) == OP_WRITE);
                be_i    <= periph_pkg::be_t'(field_of(line, F_BE));
                addr_i  <= field_of(line, F_ADDR);
                wdata_i <= field_of(line, F_DATA);
            end else begin
                req_i <= 1'b0;
                we_i  <= 1'b0;
            end
            @(negedge clk_i);
            if (rvalid_o) begin
                last_rdata = rdata_o;
                if (compare) begin
                    check_value(rdata_o, field_of(first + got, F_EXP),
                                $sformatf("op %0d rdata", first + got));
                end
                got++;
            end
            if (issued >= count) begin
                check_value(gnt_o, 1'b0, "gnt without request");
            end
            if (issued < count && gnt_o) begin
                issued++;    // held until granted
            end
        end
    endtask

    task automatic poll_value(input int line);
        int start;
        start = cycle_cnt;
        run_accesses(line, 1, 1'b0);
        while (last_rdata !== field_of(line, F_EXP) &&
               cycle_cnt - start < int'(field_of(line, F_BUDGET))) begin
            run_accesses(line, 1, 1'b0);
        end
        check_value(last_rdata, field_of(line, F_EXP), $sformatf("op %0d polled value", line));
    endtask

    task automatic wait_irq(input int line);
        int          n;
        logic [31:0] seen;
        n = 0;
        @(negedge clk_i);
        seen = {23'b0, irq_o, irq_id_o};
        while (seen !== field_of(line, F_EXP) && n < int'(field_of(line, F_BUDGET))) begin
            @(negedge clk_i);
            seen = {23'b0, irq_o, irq_id_o};
            n++;
        end
        check_value(seen, field_of(line, F_EXP), $sformatf("op %0d irq and id", line));
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        wait (cycle_cnt >= limit_cycles);
        $display("timeout: operations did not finish");
        err_cnt++;
        $display("errors: %0d", err_cnt);
        $display("Done: errors found");
        $finish;
    end

    initial begin : player
        int line;
        int count;
        int op;
        int total;
        req_i   = 1'b0;
        we_i    = 1'b0;
        be_i    = '0;
        addr_i  = '0;
        wdata_i = '0;
        rst_n_i = 1'b0;
        void'($urandom(32'h2dec));
        $readmemh("periph_golden.txt", golden);
        n_ops = 0;
        while (n_ops < MAX_OPS && !$isunknown(golden[FIELDS*n_ops])) begin
            n_ops++;
        end
        // idle gaps drawn up front so the timeout can include them
        total = 0;
        for (int i = 0; i < n_ops; i++) begin
            op = field_of(i, F_OP);
            idle[i] = (op == OP_CHAIN) ? 0 : int'($urandom % 4);
            total += 4 + idle[i];
            if (op == OP_POLL || op == OP_IRQ) begin
                total += int'(field_of(i, F_BUDGET));
            end
        end
        limit_cycles = 3 + total + 50;
        if (n_ops == 0) begin
            $display("golden file periph_golden.txt is missing or empty");
            err_cnt++;
        end
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value(gnt_o, 1'b0, "gnt after reset");
        check_value(rvalid_o, 1'b0, "rvalid after reset");
        check_value({23'b0, irq_o, irq_id_o}, 32'h0, "irq and id after reset");
        line = 0;
        while (line < n_ops) begin
            op = field_of(line, F_OP);
            count = 1;
            repeat (idle[line]) @(posedge clk_i);
            case (op)
                OP_WRITE, OP_READ: begin
                    while (line + count < n_ops && field_of(line + count, F_OP) == OP_CHAIN) begin
                        count++;
                    end
                    run_accesses(line, count, 1'b1);
                end
                OP_POLL: poll_value(line);
                OP_IRQ:  wait_irq(line);
                default: begin
                    $display("op %0d has an unknown operation code %0d", line, op);
                    err_cnt++;
                end
            endcase
            line += count;
        end
        repeat (2) @(posedge clk_i);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- periph_subsys_top.sv
`include "periph_defines.svh"

module periph_subsys_top (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                req_i,
    input  logic                we_i,
    input  periph_pkg::be_t     be_i,
    input  periph_pkg::addr_t   addr_i,
    input  periph_pkg::data_t   wdata_i,
    output logic                gnt_o,
    output logic                rvalid_o,
    output periph_pkg::data_t   rdata_o,

    output logic                irq_o,
    output periph_pkg::irq_id_t irq_id_o
);

    logic [`SLV_NUM-1:0]  slv_req;
    logic [`SLV_NUM-1:0]  slv_we;
    periph_pkg::be_t      slv_be    [`SLV_NUM];
    periph_pkg::addr_t    slv_addr  [`SLV_NUM];
    periph_pkg::data_t    slv_wdata [`SLV_NUM];
    logic [`SLV_NUM-1:0]  slv_rvalid;
    periph_pkg::data_t    slv_rdata [`SLV_NUM];
    periph_pkg::irq_vec_t irq_vec;

    obi_slave_decoder i_obi_slave_decoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .we_i         (we_i),
        .be_i         (be_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .slv_req_o    (slv_req),
        .slv_we_o     (slv_we),
        .slv_be_o     (slv_be),
        .slv_addr_o   (slv_addr),
        .slv_wdata_o  (slv_wdata),
        .slv_rvalid_i (slv_rvalid),
        .slv_rdata_i  (slv_rdata)
    );

    // grants come from the decoder, slave grants left open
    for (genvar i = 0; i < `TIMER_NUM; i++) begin : g_timer
        timer_unit i_timer_unit (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .req_i    (slv_req[i]),
            .we_i     (slv_we[i]),
            .be_i     (slv_be[i]),
            .addr_i   (slv_addr[i]),
            .wdata_i  (slv_wdata[i]),
            .gnt_o    (),
            .rvalid_o (slv_rvalid[i]),
            .rdata_o  (slv_rdata[i]),
            .irq_o    (irq_vec[i])
        );
    end

    rvic_ctrl i_rvic_ctrl (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .src_i    (irq_vec),
        .req_i    (slv_req[`TIMER_NUM]),
        .we_i     (slv_we[`TIMER_NUM]),
        .be_i     (slv_be[`TIMER_NUM]),
        .addr_i   (slv_addr[`TIMER_NUM]),
        .wdata_i  (slv_wdata[`TIMER_NUM]),
        .gnt_o    (),
        .rvalid_o (slv_rvalid[`TIMER_NUM]),
        .rdata_o  (slv_rdata[`TIMER_NUM]),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

endmodule

//--- rvic_ctrl.sv
`include "periph_defines.svh"

module rvic_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  periph_pkg::irq_vec_t src_i,

    input  logic                 req_i,
    input  logic                 we_i,
    input  periph_pkg::be_t      be_i,
    input  periph_pkg::addr_t    addr_i,
    input  periph_pkg::data_t    wdata_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output periph_pkg::data_t    rdata_o,

    output logic                 irq_o,
    output periph_pkg::irq_id_t  irq_id_o
);

    periph_pkg::irq_vec_t  enable_q;
    periph_pkg::irq_vec_t  active;
    periph_pkg::irq_id_t   sel_id;
    logic [`REG_OFF_W-1:0] offset;
    periph_pkg::data_t     rd_data;
    logic                  rvalid_q;
    periph_pkg::data_t     rdata_q;
    logic                  irq_q;
    periph_pkg::irq_id_t   irq_id_q;

    assign offset = addr_i[`REG_OFF_W-1:0];
    assign active = src_i & enable_q;

    // lowest active source wins
    always_comb begin
        sel_id = '0;
        for (int i = `TIMER_NUM - 1; i >= 0; i--) begin
            if (active[i]) begin
                sel_id = periph_pkg::irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            rvalid_q <= 1'b0;
            irq_q    <= 1'b0;
            irq_id_q <= '0;
        end else begin
            if (req_i && we_i && offset == `RVIC_ENABLE) begin
                for (int b = 0; b < `TIMER_NUM; b++) begin
                    if (be_i[b/8]) begin
                        enable_q[b] <= wdata_i[b];
                    end
                end
            end
            rvalid_q <= req_i;
            irq_q    <= |active;
            irq_id_q <= sel_id;
        end
    end

    always_comb begin
        rd_data = '0;
        if (req_i && !we_i) begin
            case (offset)
                `RVIC_ENABLE:  rd_data = periph_pkg::data_t'(enable_q);
                `RVIC_PENDING: rd_data = periph_pkg::data_t'(src_i);
                default:       rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= rd_data;
    end

    assign gnt_o    = req_i;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign irq_o    = irq_q;
    assign irq_id_o = irq_id_q;

    // id names a source that was enabled and active one cycle earlier
    a_id_valid : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        irq_o |-> |($past(active) & (periph_pkg::irq_vec_t'(1) << irq_id_o))
    );

endmodule

//--- timer_unit.sv
`include "periph_defines.svh"

module timer_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              req_i,
    input  logic              we_i,
    input  periph_pkg::be_t   be_i,
    input  periph_pkg::addr_t addr_i,
    input  periph_pkg::data_t wdata_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output periph_pkg::data_t rdata_o,

    output logic              irq_o
);

    logic                     en_q;
    logic                     ie_q;
    logic                     pend_q;
    periph_pkg::data_t        value_q;
    periph_pkg::data_t        limit_q;
    logic                     reload;
    logic [`REG_OFF_W-1:0]    offset;
    logic                     wr_ctrl;
    logic                     wr_limit;
    periph_pkg::data_t        rd_data;
    logic                     rvalid_q;
    periph_pkg::data_t        rdata_q;
    logic                     irq_q;

    assign offset   = addr_i[`REG_OFF_W-1:0];
    assign wr_ctrl  = req_i && we_i && (offset == `TMR_CTRL);
    assign wr_limit = req_i && we_i && (offset == `TMR_LIMIT);
    assign reload   = en_q && (value_q == limit_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q    <= 1'b0;
            ie_q    <= 1'b0;
            pend_q  <= 1'b0;
            value_q <= '0;
            limit_q <= '0;
        end else begin
            if (reload) begin
                value_q <= '0;
            end else if (en_q) begin
                value_q <= value_q + 1'b1;
            end
            if (wr_ctrl && be_i[0]) begin
                en_q <= wdata_i[`TMR_CTRL_EN];
                ie_q <= wdata_i[`TMR_CTRL_IE];
                if (wdata_i[`TMR_CTRL_PEND]) begin
                    pend_q <= 1'b0;    // w1c
                end
            end
            if (reload) begin
                pend_q <= 1'b1;    // a new event beats a clear
            end
            if (wr_limit) begin
                for (int b = 0; b < `BE_W; b++) begin
                    if (be_i[b]) begin
                        limit_q[8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // read mux, writes answer 0
    always_comb begin
        rd_data = '0;
        if (req_i && !we_i) begin
            case (offset)
                `TMR_CTRL:  rd_data[`TMR_CTRL_PEND:0] = {pend_q, ie_q, en_q};
                `TMR_VALUE: rd_data = value_q;
                `TMR_LIMIT: rd_data = limit_q;
                default:    rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            rvalid_q <= req_i;
            irq_q    <= pend_q & ie_q;
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= rd_data;
    end

    assign gnt_o    = req_i;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign irq_o    = irq_q;

    a_rvalid_after_req : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(rvalid_o) |-> $past(req_i)
    );

endmodule

//--- obi_slave_decoder.sv
`include "periph_defines.svh"

module obi_slave_decoder (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // master side
    input  logic                req_i,
    input  logic                we_i,
    input  periph_pkg::be_t     be_i,
    input  periph_pkg::addr_t   addr_i,
    input  periph_pkg::data_t   wdata_i,
    output logic                gnt_o,
    output logic                rvalid_o,
    output periph_pkg::data_t   rdata_o,

    // slave side, timers first, then the interrupt controller
    output logic [`SLV_NUM-1:0] slv_req_o,
    output logic [`SLV_NUM-1:0] slv_we_o,
    output periph_pkg::be_t     slv_be_o    [`SLV_NUM],
    output periph_pkg::addr_t   slv_addr_o  [`SLV_NUM],
    output periph_pkg::data_t   slv_wdata_o [`SLV_NUM],
    input  logic [`SLV_NUM-1:0] slv_rvalid_i,
    input  periph_pkg::data_t   slv_rdata_i [`SLV_NUM]
);

    logic [`SLV_NUM-1:0] hit;
    logic                unmapped;
    logic                unmapped_q;

    // window match per slave
    always_comb begin
        for (int i = 0; i < `TIMER_NUM; i++) begin
            hit[i] = (addr_i & `TIMER_MASK) == (`TIMER_BASE + i * `TIMER_STRIDE);
        end
        hit[`TIMER_NUM] = (addr_i & `RVIC_MASK) == `RVIC_BASE;
    end

    assign unmapped = ~|hit;

    // all slaves accept at once, so no stall toward the master
    assign gnt_o = req_i;

    for (genvar i = 0; i < `SLV_NUM; i++) begin : g_fanout
        assign slv_req_o[i]   = req_i & hit[i];
        assign slv_we_o[i]    = we_i;
        assign slv_be_o[i]    = be_i;
        assign slv_addr_o[i]  = addr_i;
        assign slv_wdata_o[i] = wdata_i;
    end

    // answer unmapped accesses here
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            unmapped_q <= 1'b0;
        end else begin
            unmapped_q <= req_i & unmapped;
        end
    end

    assign rvalid_o = (|slv_rvalid_i) | unmapped_q;

    always_comb begin
        rdata_o = '0;    // also the unmapped answer
        for (int i = 0; i < `SLV_NUM; i++) begin
            if (slv_rvalid_i[i]) begin
                rdata_o = slv_rdata_i[i];
            end
        end
    end

    // one request in flight per cycle, so only one slave may answer
    a_single_rvalid : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(slv_rvalid_i)
    );

endmodule

//--- periph_pkg.sv
`include "periph_defines.svh"

package periph_pkg;

    // bus address
    typedef logic [`ADDR_W-1:0] addr_t;

    // bus data word
    typedef logic [`DATA_W-1:0] data_t;

    // one bit per byte lane
    typedef logic [`BE_W-1:0] be_t;

    // one level bit per timer
    typedef logic [`TIMER_NUM-1:0] irq_vec_t;

    // id handed to the core with the request
    typedef logic [`IRQ_ID_W-1:0] irq_id_t;

endpackage

//--- periph_defines.svh
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

`define TIMER_NUM     3
`define SLV_NUM       (`TIMER_NUM + 1)    // timers, then the interrupt controller

`define ADDR_W        32
`define DATA_W        32
`define BE_W          (`DATA_W / 8)
`define IRQ_ID_W      8

// address map
`define TIMER_BASE    32'h0200_0000
`define TIMER_STRIDE  32'h0000_0100
`define TIMER_MASK    32'hffff_ff00
`define RVIC_BASE     32'h0300_0000
`define RVIC_MASK     32'hffff_ff00

// register offsets inside one window
`define REG_OFF_W     8
`define TMR_CTRL      8'h00    // [0] enable, [1] irq enable, [2] pending, w1c
`define TMR_VALUE     8'h04    // read only
`define TMR_LIMIT     8'h08

`define RVIC_ENABLE   8'h00
`define RVIC_PENDING  8'h04    // raw sources, read only

`define TMR_CTRL_EN   0
`define TMR_CTRL_IE   1
`define TMR_CTRL_PEND 2

`endif
